// ==== sbox6_engine.f ====
sbox6_pkg.sv
sbox6_power.sv
sbox6_round_core.sv
sbox6_regs.sv
sbox6_top.sv
sbox6_tb.sv

// ==== sbox6_patterns.txt ====
# opcode key din expected_dout, all hex
# opcode 0 is encrypt, opcode 1 is substitute
1 000000 000000 000000
1 A5A5A5 041041 C30C30
1 000000 FFFFFF 30C30C
1 123456 03F040 00CC00
0 000000 000000 000000
0 000000 000001 80D5D3
0 000001 000001 0612E1

// ==== sbox6_pkg.sv ====
package sbox6_pkg;

  localparam int LANE_W     = 6;
  localparam int NUM_LANES  = 4;
  localparam int BLOCK_W    = LANE_W * NUM_LANES;
  localparam int ROT_AMOUNT = 7;

  typedef logic [LANE_W-1:0]  lane_t;
  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [2:0]         gf8_t;

  // Codes 2 and 3 are reserved and flagged by the core as bad_op
  typedef enum logic [1:0] {
    OP_ENCRYPT = 2'd0,
    OP_SUBST   = 2'd1
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ROUND = 2'd1,
    ST_FINAL = 2'd2
  } core_state_e;

  // Word addresses, decoded from paddr[4:0]
  typedef enum logic [4:0] {
    REG_CTRL   = 5'h00,
    REG_STATUS = 5'h04,
    REG_KEY    = 5'h08,
    REG_DIN    = 5'h0C,
    REG_DOUT   = 5'h10
  } reg_addr_e;

  typedef struct packed {
    logic busy;
    logic done;
    logic bad_op;
  } core_status_t;

  // GF(2^3) product, reduced with x^3 = x^2 + 1 as in the tower field's base level
  function automatic gf8_t gf8_mul(gf8_t a, gf8_t b);
    logic [4:0] d;
    gf8_t       c;
    d = '0;
    for (int i = 0; i < 3; i++) begin
      if (b[i]) begin
        d = d ^ (5'(a) << i);
      end
    end
    // x^4 folds back to x^2 + x + 1
    c[0] = d[0] ^ d[3] ^ d[4];
    c[1] = d[1] ^ d[4];
    c[2] = d[2] ^ d[3] ^ d[4];
    return c;
  endfunction

  function automatic gf8_t gf8_sq(gf8_t a);
    return {a[1] ^ a[2], a[2], a[0] ^ a[2]};
  endfunction

  // Multiply by a fixed element k, built from a, a*x and a*x^2
  function automatic gf8_t gf8_mul_const(gf8_t a, gf8_t k);
    gf8_t ax;
    gf8_t ax2;
    gf8_t r;
    ax  = {a[1] ^ a[2], a[0], a[2]};
    ax2 = {ax[1] ^ ax[2], ax[0], ax[2]};
    r   = '0;
    if (k[0]) begin
      r = r ^ a;
    end
    if (k[1]) begin
      r = r ^ ax;
    end
    if (k[2]) begin
      r = r ^ ax2;
    end
    return r;
  endfunction

endpackage

// ==== sbox6_power.sv ====
`timescale 1ns/1ps
module sbox6_power (
  input  sbox6_pkg::lane_t a,
  output sbox6_pkg::lane_t y
);
  import sbox6_pkg::*;

  lane_t z;
  lane_t w;
  lane_t p;
  gf8_t  x0;
  gf8_t  x1;
  gf8_t  x0_sq;
  gf8_t  x1_sq;
  gf8_t  x0_p3;
  gf8_t  x1_p3;
  gf8_t  x0_p4;
  gf8_t  x1_p4;
  gf8_t  x0_p5;
  gf8_t  x1_p5;
  gf8_t  t2;
  gf8_t  t3;
  gf8_t  t4;
  gf8_t  t5;
  gf8_t  w_lo;
  gf8_t  w_hi;
  logic  fix;

  // Basis change from GF(2^6) into the tower field GF((2^3)^2)
  assign z[0] = a[0] ^ a[4];
  assign z[1] = a[1] ^ a[2] ^ a[4];
  assign z[2] = a[2] ^ a[3] ^ a[5];
  assign z[3] = a[4];
  assign z[4] = a[3];
  assign z[5] = a[1] ^ a[2] ^ a[4] ^ a[5];

  assign x0 = z[2:0];
  assign x1 = z[5:3];

  // Powers of each half
  assign x0_sq = gf8_sq(x0);
  assign x1_sq = gf8_sq(x1);
  assign x0_p3 = gf8_mul(x0_sq, x0);
  assign x1_p3 = gf8_mul(x1_sq, x1);
  assign x0_p4 = gf8_sq(x0_sq);
  assign x1_p4 = gf8_sq(x1_sq);
  assign x0_p5 = gf8_mul(x0_p4, x0);
  assign x1_p5 = gf8_mul(x1_p4, x1);

  // Cross terms of the expansion of (x1*t + x0)^26
  assign t2 = gf8_mul(x0_p4, x1);
  assign t3 = gf8_mul(x1_p4, x0);
  assign t4 = gf8_mul(x0_p3, x1_sq);
  assign t5 = gf8_mul(x1_p3, x0_sq);

  assign w_lo = x0_p5
              ^ gf8_mul_const(x1_p5, 3'd3)
              ^ gf8_mul_const(t2, 3'd4)
              ^ gf8_mul_const(t3, 3'd7)
              ^ gf8_mul_const(t4, 3'd7)
              ^ gf8_mul_const(t5, 3'd3);

  // Only three terms reach the high half
  assign w_hi = gf8_mul_const(x1_p5, 3'd7)
              ^ t2
              ^ gf8_mul_const(t5, 3'd7);

  assign w = {w_hi, w_lo};

  // Back to the polynomial basis
  assign p[0] = w[1] ^ w[2] ^ w[3] ^ w[4] ^ w[5];
  assign p[1] = w[2] ^ w[3] ^ w[5];
  assign p[2] = w[1] ^ w[2] ^ w[5];
  assign p[3] = w[2] ^ w[5];
  assign p[4] = w[0] ^ w[1] ^ w[5];
  assign p[5] = w[0] ^ w[2] ^ w[3];

  // Affine correction driven by the original input
  assign fix = a[2] ^ a[4];
  assign y   = p ^ {LANE_W{fix}};

endmodule

// ==== sbox6_regs.sv ====
`timescale 1ns/1ps
module sbox6_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [7:0]              paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    start,
  output sbox6_pkg::op_e          op,
  output sbox6_pkg::block_t       key,
  output sbox6_pkg::block_t       din,
  input  sbox6_pkg::core_status_t status,
  input  sbox6_pkg::block_t       dout
);
  import sbox6_pkg::*;

  reg_addr_e addr;
  logic      access;
  logic      mapped;
  logic      ro_hit;
  logic      busy_hit;
  logic      err;
  logic      wr_en;

  assign addr   = reg_addr_e'(paddr[4:0]);
  assign access = psel & penable;

  always_comb begin
    mapped = 1'b0;
    if (paddr[7:5] == 3'b000) begin
      case (addr)
        REG_CTRL, REG_STATUS, REG_KEY, REG_DIN, REG_DOUT: mapped = 1'b1;
        default: mapped = 1'b0;
      endcase
    end
  end

  // STATUS and DOUT are read only
  assign ro_hit = pwrite & ((addr == REG_STATUS) | (addr == REG_DOUT));

  // Operands and control are locked while the core runs
  assign busy_hit = pwrite & status.busy
                  & ((addr == REG_CTRL) | (addr == REG_KEY) | (addr == REG_DIN));

  assign err     = ~mapped | ro_hit | busy_hit;
  assign pslverr = access & err;
  assign wr_en   = access & pwrite & ~err;
  assign pready  = 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start <= 1'b0;
      op    <= OP_ENCRYPT;
      key   <= '0;
      din   <= '0;
    end else begin
      // start is a single-cycle pulse
      start <= 1'b0;
      if (wr_en) begin
        case (addr)
          REG_CTRL: begin
            start <= pwdata[0];
            op    <= op_e'(pwdata[2:1]);
          end
          REG_KEY: key <= pwdata[BLOCK_W-1:0];
          REG_DIN: din <= pwdata[BLOCK_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (mapped) begin
      case (addr)
        REG_CTRL:   prdata[2:0] = {op, start};
        REG_STATUS: prdata[$bits(core_status_t)-1:0] = status;
        REG_KEY:    prdata[BLOCK_W-1:0] = key;
        REG_DIN:    prdata[BLOCK_W-1:0] = din;
        REG_DOUT:   prdata[BLOCK_W-1:0] = dout;
        default:    prdata = '0;
      endcase
    end
  end

  // The master must open every transfer with psel before the access phase
  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel)
    else $error("penable without psel");

endmodule

// ==== sbox6_round_core.sv ====
`timescale 1ns/1ps
module sbox6_round_core #(
  parameter int NUM_ROUNDS = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  sbox6_pkg::op_e          op,
  input  sbox6_pkg::block_t       key,
  input  sbox6_pkg::block_t       din,
  output sbox6_pkg::block_t       dout,
  output sbox6_pkg::core_status_t status
);
  import sbox6_pkg::*;

  localparam int CNT_W = $clog2(NUM_ROUNDS + 1);

  core_state_e      state_q;
  logic [CNT_W-1:0] round_q;
  block_t           blk_q;
  logic             done_q;
  logic             bad_op_q;
  block_t           key_rot;
  block_t           sbox_in;
  block_t           sbox_out;

  function automatic block_t rotl(block_t x, int unsigned n);
    return block_t'((x << n) | (x >> (BLOCK_W - n)));
  endfunction

  // In ST_FINAL the counter holds NUM_ROUNDS, so the same rotator gives the whitening key
  always_comb begin
    key_rot = rotl(key, (LANE_W * int'(round_q)) % BLOCK_W);
    sbox_in = (state_q == ST_ROUND) ? (blk_q ^ key_rot) : din;
  end

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    sbox6_power u_sbox (
      .a (sbox_in[i*LANE_W +: LANE_W]),
      .y (sbox_out[i*LANE_W +: LANE_W])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ST_IDLE;
      round_q  <= '0;
      blk_q    <= '0;
      done_q   <= 1'b0;
      bad_op_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            round_q  <= '0;
            done_q   <= 1'b0;
            bad_op_q <= 1'b0;
            case (op)
              OP_ENCRYPT: begin
                blk_q   <= din;
                state_q <= ST_ROUND;
              end
              OP_SUBST: begin
                blk_q  <= sbox_out;
                done_q <= 1'b1;
              end
              default: begin
                done_q   <= 1'b1;
                bad_op_q <= 1'b1;
              end
            endcase
          end
        end
        ST_ROUND: begin
          blk_q   <= rotl(sbox_out, ROT_AMOUNT);
          round_q <= round_q + 1'b1;
          if (round_q == CNT_W'(NUM_ROUNDS - 1)) begin
            state_q <= ST_FINAL;
          end
        end
        ST_FINAL: begin
          blk_q   <= blk_q ^ key_rot;
          done_q  <= 1'b1;
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign dout          = blk_q;
  assign status.busy   = (state_q != ST_IDLE);
  assign status.done   = done_q;
  assign status.bad_op = bad_op_q;

  // The register block must hold off a new start until the current block is done
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(start && status.busy))
    else $error("start while core busy");

  a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(status.busy && status.done))
    else $error("busy and done both set");

  a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
    round_q <= CNT_W'(NUM_ROUNDS))
    else $error("round counter out of range");

endmodule

// ==== sbox6_tb.sv ====
`timescale 1ns/1ps
module sbox6_tb;

  localparam int NUM_ROUNDS   = 4;
  localparam int CLK_PERIOD   = 100;
  localparam int MAX_PATTERNS = 32;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] pat_op  [MAX_PATTERNS];
  logic [31:0] pat_key [MAX_PATTERNS];
  logic [31:0] pat_din [MAX_PATTERNS];
  logic [31:0] pat_exp [MAX_PATTERNS];
  int          num_patterns;
  int          errors;
  int          checks;
  logic        loaded;
  logic [15:0] lfsr;

  sbox6_top #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // One transfer, setup then access; outputs are sampled mid access phase
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    rdata = prdata;
    err   = pslverr;
    check("pready", 32'd1, pready);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input string name,
                             input logic [31:0] expected);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rd, err);
    check(name, expected, rd);
  endtask

  task automatic wait_done(input string what);
    logic [31:0] st;
    logic        err;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < NUM_ROUNDS + 10) begin
      apb_xfer(1'b0, 8'h04, 32'd0, st, err);
      polls++;
    end
    if (!st[1]) begin
      errors++;
      $display("STATUS.done never came up during %s", what);
    end
  endtask

  initial begin
    logic [31:0]      rd;
    logic             err;
    logic [31:0]      wkey;
    logic [31:0]      wdin;
    logic [31:0]      saved;
    logic [8*128-1:0] line;
    int               fd;
    int               cnt;
    clk          = 1'b0;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    errors       = 0;
    checks       = 0;
    num_patterns = 0;
    lfsr         = 16'd50;
    fd = $fopen("sbox6_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open sbox6_patterns.txt");
    end else begin
      while (!$feof(fd) && num_patterns < MAX_PATTERNS) begin
        line = '0;
        cnt  = $fgets(line, fd);
        cnt  = $sscanf(line, "%h %h %h %h", pat_op[num_patterns], pat_key[num_patterns],
                       pat_din[num_patterns], pat_exp[num_patterns]);
        if (cnt == 4) begin
          num_patterns++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_expect(8'h04, "STATUS", 32'd0);
    read_expect(8'h10, "DOUT", 32'd0);
    read_expect(8'h08, "KEY", 32'd0);
    read_expect(8'h0C, "DIN", 32'd0);

    random_word(wkey);
    random_word(wdin);
    apb_xfer(1'b1, 8'h08, wkey, rd, err);
    check("pslverr", 32'd0, err);
    apb_xfer(1'b1, 8'h0C, wdin, rd, err);
    read_expect(8'h08, "KEY", {8'h00, wkey[23:0]});
    read_expect(8'h0C, "DIN", {8'h00, wdin[23:0]});

    for (int i = 0; i < num_patterns; i++) begin
      apb_xfer(1'b1, 8'h08, pat_key[i], rd, err);
      apb_xfer(1'b1, 8'h0C, pat_din[i], rd, err);
      apb_xfer(1'b1, 8'h00, {29'd0, pat_op[i][1:0], 1'b1}, rd, err);
      check("pslverr", 32'd0, err);
      wait_done("a pattern operation");
      read_expect(8'h10, "DOUT", pat_exp[i]);
    end

    // DIN is locked while the encryption runs
    apb_xfer(1'b0, 8'h0C, 32'd0, saved, err);
    apb_xfer(1'b1, 8'h00, 32'h1, rd, err);
    apb_xfer(1'b1, 8'h0C, ~saved, rd, err);
    check("pslverr", 32'd1, err);
    wait_done("the busy write test");
    read_expect(8'h0C, "DIN", saved);

    apb_xfer(1'b0, 8'h14, 32'd0, rd, err);
    check("pslverr", 32'd1, err);
    apb_xfer(1'b1, 8'h04, 32'h7, rd, err);
    check("pslverr", 32'd1, err);

    // Opcode 3 is reserved
    apb_xfer(1'b0, 8'h10, 32'd0, saved, err);
    apb_xfer(1'b1, 8'h00, 32'h7, rd, err);
    wait_done("the reserved opcode test");
    read_expect(8'h04, "STATUS", 32'h3);
    read_expect(8'h10, "DOUT", saved);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    wait (loaded === 1'b1);
    #((num_patterns + 20) * (NUM_ROUNDS + 10) * 2 * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== sbox6_top.sv ====
`timescale 1ns/1ps
module sbox6_top #(
  parameter int NUM_ROUNDS = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import sbox6_pkg::*;

  logic         start;
  op_e          op;
  block_t       key;
  block_t       din;
  block_t       dout;
  core_status_t status;

  sbox6_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .op      (op),
    .key     (key),
    .din     (din),
    .status  (status),
    .dout    (dout)
  );

  sbox6_round_core #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) u_core (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .op     (op),
    .key    (key),
    .din    (din),
    .dout   (dout),
    .status (status)
  );

endmodule
